// ==== logic/st_mem_settings.svh ====
// Values must stay consistent with 64-bit words and 8-byte strobes in the package types
`ifndef ST_MEM_SETTINGS_SVH
`define ST_MEM_SETTINGS_SVH

// Store buffer sizing, power of two and at least 2
`define ST_BUF_DEPTH 8

// Datapath widths
`define ADDR_W 32
`define DATA_W 64   // Eight byte lanes

// Data memory, 64-bit words
`define DMEM_WORDS 256

// Configuration port
`define CFG_ADDR_W     2
`define CFG_DRAIN_ADDR 0  // Bit 0 is drain_en
`define CFG_FLUSH_ADDR 1  // Bit 0 set fires a flush pulse

`endif

// ==== logic/st_mem_pkg.sv ====
// Types assume DATA_W of 64 so that strobes and size codes cover one 8-byte word
`default_nettype none

`include "st_mem_settings.svh"

package st_mem_pkg;

    // Plain vectors with a meaning
    typedef logic [`ADDR_W-1:0]   addr_t;   // Byte address
    typedef logic [`DATA_W-1:0]   data_t;   // One memory word
    typedef logic [1:0]           size_t;   // log2 of access bytes
    typedef logic [`DATA_W/8-1:0] strb_t;   // One bit per byte lane

    // Committed store as it enters the buffer
    typedef struct packed {
        addr_t addr;
        data_t data;    // Value sits in the low bytes
        size_t size;
    } st_req_t;

    // Load request, data comes back on the response channel
    typedef struct packed {
        addr_t addr;
        size_t size;
    } ld_req_t;

    // One command per cycle on the memory port
    typedef struct packed {
        addr_t addr;
        data_t wdata;   // Already shifted to its byte lanes
        strb_t strb;
        logic  we;
        logic  re;
    } dmem_req_t;

    // Drain FSM, tracks whether the last cycle wrote memory
    typedef enum logic {
        DRN_IDLE  = 1'b0,
        DRN_WRITE = 1'b1
    } drain_state_t;

endpackage

`default_nettype wire

// ==== logic/store_buffer.sv ====
// Aligned accesses only and collisions compare address bits 11 down so aliasing is conservative
`default_nettype none

`include "st_mem_settings.svh"

module store_buffer #(
    parameter int DEPTH = `ST_BUF_DEPTH  // Power of two, 2 or more
) (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,

    // Store channel from commit
    input  wire logic                 st_valid_i,
    output logic                      st_ready_o,
    input  wire st_mem_pkg::st_req_t  st_req_i,

    input  wire logic                 flush_i,      // Drop everything not yet drained
    input  wire logic                 pop_i,        // Head was written to memory

    input  wire st_mem_pkg::ld_req_t  ld_req_i,     // Load being checked this cycle

    output st_mem_pkg::st_req_t       head_o,       // Oldest pending store
    output logic                      head_valid_o,
    output logic                      collision_o   // Load overlaps a pending store
);

    import st_mem_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;   // Needs to reach DEPTH itself

    // Entry storage, payload only
    st_req_t entry_q [DEPTH];
    logic [DEPTH-1:0] valid_q;          // One bit per slot

    logic [PTR_W-1:0] head_q;           // Oldest entry
    logic [PTR_W-1:0] tail_q;           // Next free slot
    logic [CNT_W-1:0] count_q;

    logic push;
    logic pop_en;

    // Same 8..1 byte block check as the hardware table walk uses
    function automatic logic addr_overlap(addr_t a, size_t a_size, addr_t b, size_t b_size);
        size_t       big;
        logic [11:0] mask;
        big  = (a_size > b_size) ? a_size : b_size;
        mask = 12'hfff << big;            // Ignore bits inside the larger access
        return ((a[11:0] ^ b[11:0]) & mask) == 12'h000;
    endfunction

    // Full or flushing blocks new stores
    assign st_ready_o = (count_q < CNT_W'(DEPTH)) && !flush_i;
    assign push       = st_valid_i && st_ready_o;
    assign pop_en     = pop_i && (count_q != '0);   // Guard against popping empty

    // Slot valid bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                // Pending stores are lost
        end else begin
            if (pop_en) begin
                valid_q[head_q] <= 1'b0;
            end
            if (push) begin
                valid_q[tail_q] <= 1'b1;
            end
        end
    end

    // Payload write, no reset needed
    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_q[tail_q] <= st_req_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(pop_en);    // Wraps at DEPTH
            tail_q  <= tail_q + PTR_W'(push);
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop_en);
        end
    end

    // Head offered to the drain logic
    assign head_o       = entry_q[head_q];
    assign head_valid_o = valid_q[head_q] && !flush_i;  // No drain in the flush cycle

    // Collision check against every live entry
    always_comb begin
        collision_o = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] &&
                addr_overlap(entry_q[i].addr, entry_q[i].size,
                             ld_req_i.addr, ld_req_i.size)) begin
                collision_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_cfg_regs.sv ====
// Write-only block with no read-back and only bit 0 of the write data is decoded
`default_nettype none

`include "st_mem_settings.svh"

module mem_cfg_regs (
    input  wire logic                   clk_i,
    input  wire logic                   rstn_i,
    input  wire logic                   cfg_we_i,
    input  wire logic [`CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire st_mem_pkg::data_t      cfg_wdata_i,
    output logic                        drain_en_o,  // Held enable
    output logic                        flush_o      // One-cycle pulse
);

    logic drain_wr;
    logic flush_wr;

    // Address decode
    assign drain_wr = cfg_we_i && (cfg_addr_i == `CFG_ADDR_W'(`CFG_DRAIN_ADDR));
    assign flush_wr = cfg_we_i && (cfg_addr_i == `CFG_ADDR_W'(`CFG_FLUSH_ADDR));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            drain_en_o <= 1'b0;           // Stores stay buffered until enabled
            flush_o    <= 1'b0;
        end else begin
            if (drain_wr) begin
                drain_en_o <= cfg_wdata_i[0];
            end
            // Self clearing, high only in the cycle after the write
            flush_o <= flush_wr && cfg_wdata_i[0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_ctrl.sv ====
// Loads always win the port and the response consumer can never stall
`default_nettype none

module lsu_ctrl (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    // Load request channel
    input  wire logic                  ld_valid_i,
    output logic                       ld_ready_o,
    input  wire st_mem_pkg::ld_req_t   ld_req_i,

    // Store buffer side
    input  wire logic                  collision_i,
    input  wire st_mem_pkg::st_req_t   head_i,
    input  wire logic                  head_valid_i,
    input  wire logic                  drain_en_i,
    output logic                       pop_o,

    // Memory port
    output st_mem_pkg::dmem_req_t      dmem_req_o,
    input  wire st_mem_pkg::data_t     dmem_rdata_i,

    // Load response, valid only
    output logic                       ld_rsp_valid_o,
    output st_mem_pkg::data_t          ld_rsp_data_o
);

    import st_mem_pkg::*;

    drain_state_t state_q;
    drain_state_t state_d;

    logic       ld_fire;
    logic       drain_go;
    logic [2:0] rsp_off_q;   // Byte offset of the accepted load
    size_t      rsp_size_q;

    // Strobe pattern for an access at offset 0
    function automatic strb_t size_strb(size_t size);
        case (size)
            2'd0:    return strb_t'(8'h01);
            2'd1:    return strb_t'(8'h03);
            2'd2:    return strb_t'(8'h0f);
            default: return strb_t'(8'hff);
        endcase
    endfunction

    // Shift the addressed bytes down and zero-extend
    function automatic data_t align_rsp(data_t raw, logic [2:0] off, size_t size);
        data_t sh;
        sh = raw >> {off, 3'b000};
        case (size)
            2'd0:    return data_t'(sh[7:0]);
            2'd1:    return data_t'(sh[15:0]);
            2'd2:    return data_t'(sh[31:0]);
            default: return sh;
        endcase
    endfunction

    // Arbitration, load before drain
    assign ld_ready_o = ld_valid_i && !collision_i;  // Stall until older stores drain
    assign ld_fire    = ld_ready_o;
    assign drain_go   = drain_en_i && head_valid_i && !ld_fire;
    assign pop_o      = drain_go;                    // Pop in the write cycle

    // Idle or write, decided by this cycle's grant
    assign state_d = drain_go ? DRN_WRITE : DRN_IDLE;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= DRN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Memory command mux
    always_comb begin
        dmem_req_o = '0;
        if (ld_fire) begin
            dmem_req_o.addr = ld_req_i.addr;
            dmem_req_o.re   = 1'b1;
        end else if (drain_go) begin
            dmem_req_o.addr  = head_i.addr;
            dmem_req_o.wdata = head_i.data << {head_i.addr[2:0], 3'b000};  // Into its lanes
            dmem_req_o.strb  = size_strb(head_i.size) << head_i.addr[2:0];
            dmem_req_o.we    = 1'b1;
        end else begin
            // Idle port, keep the address on the stream that used it last
            dmem_req_o.addr = (state_q == DRN_WRITE) ? head_i.addr : ld_req_i.addr;
        end
    end

    // Response valid one cycle after accept
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ld_rsp_valid_o <= 1'b0;
        end else begin
            ld_rsp_valid_o <= ld_fire;
        end
    end

    // Offset and size for alignment in the response cycle
    always_ff @(posedge clk_i) begin
        if (ld_fire) begin
            rsp_off_q  <= ld_req_i.addr[2:0];
            rsp_size_q <= ld_req_i.size;
        end
    end

    assign ld_rsp_data_o = align_rsp(dmem_rdata_i, rsp_off_q, rsp_size_q);

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
// Address bits above the word index are ignored so the memory aliases across the space
`default_nettype none

`include "st_mem_settings.svh"

module data_mem (
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    input  wire st_mem_pkg::dmem_req_t   dmem_req_i,
    output st_mem_pkg::data_t            rdata_o     // One cycle after re
);

    import st_mem_pkg::*;

    localparam int IDX_W  = $clog2(`DMEM_WORDS);   // 8 for 256 words
    localparam int LANES  = `DATA_W / 8;

    data_t mem_q [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    // Word index, bits 10 to 3 by default
    assign idx = dmem_req_i.addr[IDX_W+2:3];

    // Byte-strobed write, cleared on reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int w = 0; w < `DMEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (dmem_req_i.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (dmem_req_i.strb[b]) begin
                    mem_q[idx][b*8 +: 8] <= dmem_req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rdata_o <= '0;
        end else if (dmem_req_i.re) begin
            rdata_o <= mem_q[idx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/st_mem_top.sv ====
// Drained stores reach memory in order and a colliding load waits with drain disabled forever
`default_nettype none

`include "st_mem_settings.svh"

module st_mem_top (
    input  wire logic                   clk_i,
    input  wire logic                   rstn_i,

    // Store channel
    input  wire logic                   st_valid_i,
    output logic                        st_ready_o,
    input  wire st_mem_pkg::st_req_t    st_req_i,

    // Load channel and response
    input  wire logic                   ld_valid_i,
    output logic                        ld_ready_o,
    input  wire st_mem_pkg::ld_req_t    ld_req_i,
    output logic                        ld_rsp_valid_o,
    output st_mem_pkg::data_t           ld_rsp_data_o,

    // Configuration writes
    input  wire logic                   cfg_we_i,
    input  wire logic [`CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire st_mem_pkg::data_t      cfg_wdata_i
);

    import st_mem_pkg::*;

    logic      drain_en;
    logic      flush;
    st_req_t   head;
    logic      head_valid;
    logic      collision;
    logic      pop;
    dmem_req_t dmem_req;
    data_t     dmem_rdata;

    store_buffer #(.DEPTH(`ST_BUF_DEPTH)) store_buffer0 (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .st_valid_i   (st_valid_i),
        .st_ready_o   (st_ready_o),
        .st_req_i     (st_req_i),
        .flush_i      (flush),
        .pop_i        (pop),
        .ld_req_i     (ld_req_i),
        .head_o       (head),
        .head_valid_o (head_valid),
        .collision_o  (collision)
    );

    mem_cfg_regs mem_cfg_regs0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .drain_en_o  (drain_en),
        .flush_o     (flush)
    );

    lsu_ctrl lsu_ctrl0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .ld_valid_i     (ld_valid_i),
        .ld_ready_o     (ld_ready_o),
        .ld_req_i       (ld_req_i),
        .collision_i    (collision),
        .head_i         (head),
        .head_valid_i   (head_valid),
        .drain_en_i     (drain_en),
        .pop_o          (pop),
        .dmem_req_o     (dmem_req),
        .dmem_rdata_i   (dmem_rdata),
        .ld_rsp_valid_o (ld_rsp_valid_o),
        .ld_rsp_data_o  (ld_rsp_data_o)
    );

    data_mem data_mem0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .dmem_req_i (dmem_req),
        .rdata_o    (dmem_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/st_mem_tb.sv ====
// Addresses stay below 0x800 since memory aliases above bit 10, and flushes only run with drain off
`default_nettype none

`include "st_mem_settings.svh"

module st_mem_tb;

    import st_mem_pkg::*;

    localparam int SETTLE_CYCLES = `ST_BUF_DEPTH + 2;  // Full buffer drains one per cycle
    localparam int MEM_BYTES     = `DMEM_WORDS * 8;

    // Kinds of table step
    typedef enum int {
        S_CFG,      // addr is the config address and val the data bit
        S_STORE,
        S_LOAD,     // Load whose data is compared with the model
        S_STALL,    // Load that must see ready low for cycles
        S_STRDY     // st_ready_o must equal val for cycles
    } step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        addr_t      addr;
        size_t      size;
        int         val;
        int         cycles;
    } step_t;

    // DUT side
    logic                   clk;
    logic                   rstn;
    logic                   st_valid;
    logic                   st_ready;
    st_req_t                st_req;
    logic                   ld_valid;
    logic                   ld_ready;
    ld_req_t                ld_req;
    logic                   ld_rsp_valid;
    data_t                  ld_rsp_data;
    logic                   cfg_we;
    logic [`CFG_ADDR_W-1:0] cfg_addr;
    data_t                  cfg_wdata;

    // Model state
    step_t       table_q[$];
    st_req_t     pending_q[$];          // Accepted while draining was off
    logic [7:0]  shadow_mem [MEM_BYTES]; // Bytes known to be in memory
    logic        drain_on;              // Copy of drain_en
    logic        ld_held;               // Stall step left ld_valid high
    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;
    int          cycle_limit = 100;

    st_mem_top dut0 (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .st_valid_i     (st_valid),
        .st_ready_o     (st_ready),
        .st_req_i       (st_req),
        .ld_valid_i     (ld_valid),
        .ld_ready_o     (ld_ready),
        .ld_req_i       (ld_req),
        .ld_rsp_valid_o (ld_rsp_valid),
        .ld_rsp_data_o  (ld_rsp_data),
        .cfg_we_i       (cfg_we),
        .cfg_addr_i     (cfg_addr),
        .cfg_wdata_i    (cfg_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog on total cycles
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run timed out after %0d cycles before the table finished", cycle_cnt);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] galois_step(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int nbits, output data_t val);
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_q = galois_step(lfsr_q);
            val[b] = lfsr_q[0];
        end
    endtask

    function automatic int span_bytes(size_t size);
        return 1 << size;   // Access length in bytes
    endfunction

    task automatic commit_store(input st_req_t r);
        int base;
        base = int'(r.addr[10:0]);
        for (int k = 0; k < span_bytes(r.size); k++) begin
            shadow_mem[base + k] = r.data[8*k +: 8];  // Low bytes of data go to addr upward
        end
    endtask

    // Memory bytes with older pending stores applied and zero-extended
    function automatic data_t expect_load(addr_t a, size_t size);
        data_t res;
        int    byte_addr;
        int    base;
        res = '0;
        for (int k = 0; k < span_bytes(size); k++) begin
            byte_addr = int'(a[10:0]) + k;
            res[8*k +: 8] = shadow_mem[byte_addr];
            foreach (pending_q[i]) begin        // Younger stores win
                base = int'(pending_q[i].addr[10:0]);
                if (byte_addr >= base && byte_addr < base + span_bytes(pending_q[i].size)) begin
                    res[8*k +: 8] = pending_q[i].data[8*(byte_addr - base) +: 8];
                end
            end
        end
        return res;
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic cfg_write(input int addr, input int val);
        if (addr == `CFG_DRAIN_ADDR && val == 0 && drain_on) begin
            repeat (SETTLE_CYCLES) @(posedge clk);  // Buffer empties before drain stops
        end
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= `CFG_ADDR_W'(addr);
        cfg_wdata <= data_t'(val);
        @(posedge clk);
        cfg_we    <= 1'b0;
        if (addr == `CFG_DRAIN_ADDR) begin
            drain_on = (val != 0);
            if (drain_on) begin
                foreach (pending_q[i]) begin
                    commit_store(pending_q[i]);     // All of them drain eventually
                end
                pending_q.delete();
            end
        end else if (addr == `CFG_FLUSH_ADDR && val != 0) begin
            pending_q.delete();                     // Never reach memory
        end
    endtask

    task automatic send_store(input addr_t addr, input size_t size);
        st_req_t req;
        data_t   val;
        draw_bits(8 * span_bytes(size), val);
        req.addr = addr;
        req.data = val;
        req.size = size;
        @(posedge clk);
        st_valid <= 1'b1;
        st_req   <= req;
        do begin
            @(negedge clk);
        end while (!st_ready);
        @(posedge clk);     // Transfer edge
        st_valid <= 1'b0;
        if (drain_on) begin
            commit_store(req);
        end else begin
            pending_q.push_back(req);
        end
    endtask

    task automatic issue_load(input addr_t addr, input size_t size);
        ld_req_t req;
        data_t   exp;
        req.addr = addr;
        req.size = size;
        if (!ld_held) begin
            @(posedge clk);
            ld_valid <= 1'b1;
            ld_req   <= req;
        end else if (ld_req !== req) begin
            $display("Held load request at time %0t does not match the table step", $time);
            $display("Checks failed");
            $fatal(1, "table error");
        end
        do begin
            @(negedge clk);
        end while (!ld_ready);
        exp = expect_load(addr, size);
        @(posedge clk);     // Accept edge
        ld_valid <= 1'b0;
        ld_held = 1'b0;
        @(negedge clk);
        check_flag("ld_rsp_valid_o", 1'b1, ld_rsp_valid);
        check_data("ld_rsp_data_o", exp, ld_rsp_data);
        @(negedge clk);
        check_flag("ld_rsp_valid_o", 1'b0, ld_rsp_valid);  // Exactly one cycle
    endtask

    // Load stays valid afterwards until a later S_LOAD finishes it
    task automatic hold_load(input addr_t addr, input size_t size, input int cycles);
        ld_req_t req;
        req.addr = addr;
        req.size = size;
        @(posedge clk);
        ld_valid <= 1'b1;
        ld_req   <= req;
        ld_held = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_flag("ld_ready_o", 1'b0, ld_ready);
        end
    endtask

    task automatic expect_st_ready(input int val, input int cycles);
        @(posedge clk);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("st_ready_o", val != 0, st_ready);
        end
    endtask

    function automatic step_t make_step(step_kind_e kind, int addr, int size, int val,
                                        int cycles);
        step_t s;
        s.kind   = kind;
        s.addr   = addr_t'(addr);
        s.size   = size_t'(size);
        s.val    = val;
        s.cycles = cycles;
        return s;
    endfunction

    task automatic build_table();
        // Drain on with a double store loaded back
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 1, 0));
        table_q.push_back(make_step(S_STORE, 'h100, 3, 0, 0));
        table_q.push_back(make_step(S_LOAD, 'h100, 3, 0, 0));
        table_q.push_back(make_step(S_STORE, 'h300, 3, 0, 0));   // Old data for later
        table_q.push_back(make_step(S_STORE, 'h048, 2, 0, 0));
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 0, 0));
        // Colliding load held off until drain is enabled
        table_q.push_back(make_step(S_STORE, 'h180, 3, 0, 0));
        table_q.push_back(make_step(S_STALL, 'h180, 3, 0, 10));
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 1, 0));
        table_q.push_back(make_step(S_LOAD, 'h180, 3, 0, 0));
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 0, 0));
        // Different block goes straight to memory
        table_q.push_back(make_step(S_STORE, 'h200, 3, 0, 0));
        table_q.push_back(make_step(S_LOAD, 'h300, 3, 0, 0));
        // Flush drops both pending stores
        table_q.push_back(make_step(S_STORE, 'h300, 2, 0, 0));
        table_q.push_back(make_step(S_CFG, `CFG_FLUSH_ADDR, 0, 1, 0));
        table_q.push_back(make_step(S_STRDY, 0, 0, 1, 1));
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 1, 0));
        table_q.push_back(make_step(S_LOAD, 'h300, 3, 0, 0));
        table_q.push_back(make_step(S_LOAD, 'h200, 3, 0, 0));
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 0, 0));
        // Fill the buffer exactly
        for (int i = 0; i < `ST_BUF_DEPTH; i++) begin
            table_q.push_back(make_step(S_STORE, 'h400 + 8 * i, i % 4, 0, 0));
        end
        table_q.push_back(make_step(S_STRDY, 0, 0, 0, 5));
        table_q.push_back(make_step(S_CFG, `CFG_FLUSH_ADDR, 0, 1, 0));
        table_q.push_back(make_step(S_STRDY, 0, 0, 1, 1));
        // Byte store at offset 5 against loads of the same block
        table_q.push_back(make_step(S_STORE, 'h105, 0, 0, 0));
        table_q.push_back(make_step(S_LOAD, 'h104, 0, 0, 0));    // Neighbour byte without a stall
        table_q.push_back(make_step(S_STALL, 'h100, 3, 0, 5));
        table_q.push_back(make_step(S_CFG, `CFG_DRAIN_ADDR, 0, 1, 0));
        table_q.push_back(make_step(S_LOAD, 'h100, 3, 0, 0));
        table_q.push_back(make_step(S_LOAD, 'h048, 1, 0, 0));    // Half of an old word
        table_q.push_back(make_step(S_LOAD, 'h04c, 2, 0, 0));
    endtask

    initial begin
        step_t st;
        rstn      = 1'b0;
        st_valid  = 1'b0;
        st_req    = '0;
        ld_valid  = 1'b0;
        ld_req    = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        drain_on  = 1'b0;   // Reset value of drain_en
        ld_held   = 1'b0;
        lfsr_q    = 16'd97;
        foreach (shadow_mem[i]) begin
            shadow_mem[i] = 8'h00;  // Memory clears on reset
        end
        build_table();
        cycle_limit = 20 * table_q.size() + 100;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("st_ready_o", 1'b1, st_ready);
        check_flag("ld_rsp_valid_o", 1'b0, ld_rsp_valid);
        foreach (table_q[i]) begin
            st = table_q[i];
            case (st.kind)
                S_CFG:   cfg_write(int'(st.addr), st.val);
                S_STORE: send_store(st.addr, st.size);
                S_LOAD:  issue_load(st.addr, st.size);
                S_STALL: hold_load(st.addr, st.size, st.cycles);
                default: expect_st_ready(st.val, st.cycles);
            endcase
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== st_mem.f ====
+incdir+logic
logic/st_mem_pkg.sv
logic/store_buffer.sv
logic/mem_cfg_regs.sv
logic/lsu_ctrl.sv
logic/data_mem.sv
logic/st_mem_top.sv
verif/st_mem_tb.sv

// ==== Makefile ====
# Verilator flow, every variable can be overridden on the command line
VERILATOR ?= verilator
FLIST     ?= st_mem.f
TB_TOP    ?= st_mem_tb
RTL_TOP   ?= st_mem_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
